/* verilog/cache_pkg.sv */
// ----------------------------------------------------------
// shared types and default sizes for the split l1 caches
// byte addresses with the low two bits ignored
// only whole 32-bit words move between cpu, caches and memory
// ----------------------------------------------------------

package cache_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  typedef logic [31:0] word_t;   // one data word
  typedef logic [31:0] addr_t;   // byte address

  // ----------------------------------------------------------
  // request bundles
  // ----------------------------------------------------------

  // cpu side request, we is tied low toward the icache
  typedef struct packed {
    logic  we;      // high for a store
    addr_t addr;    // word aligned use only
    word_t wdata;   // store data
  } cpu_req_t;      // 65 bits

  // request toward main memory, same layout as the cpu side
  typedef struct packed {
    logic  we;      // write through store
    addr_t addr;    // memory drops bits above its own size
    word_t wdata;   // ignored on reads
  } mem_req_t;      // 65 bits

  // ----------------------------------------------------------
  // default parameter values
  // ----------------------------------------------------------
  localparam int INDEX_BITS_DEF = 6;    // 64 lines per cache
  localparam int MEM_AW_DEF     = 12;   // 4096 words of memory
  localparam int MEM_LAT_DEF    = 4;    // memory response latency, min 1

endpackage

/* verilog/icache.sv */
// ----------------------------------------------------------
// read only direct mapped instruction cache, one word per line
// not snooped, so a line stays stale after a data store
// cpu must not strobe req while busy is high
// ----------------------------------------------------------

module icache #(
  parameter int INDEX_BITS = cache_pkg::INDEX_BITS_DEF
) (
  input  logic                clk,
  input  logic                arst_n,
  // cpu side
  input  logic                req,
  input  cache_pkg::addr_t    addr,
  output logic                rsp,
  output cache_pkg::word_t    rdata,
  output logic                busy,
  // memory side
  output logic                mem_req,
  output cache_pkg::mem_req_t mem_req_data,
  input  logic                mem_rsp,
  input  cache_pkg::word_t    mem_rdata
);

  localparam int LINES    = 1 << INDEX_BITS;
  localparam int TAG_BITS = 30 - INDEX_BITS;

  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]   tag_t;
  typedef enum logic [1:0] {idle, lookup, wait_mem} state_t;

  state_t           state;
  state_t           state_nxt;
  logic [LINES-1:0] valid;              // one valid bit per line
  tag_t             tag_mem  [LINES];
  cache_pkg::word_t data_mem [LINES];

  cache_pkg::addr_t addr_q;             // address under service
  logic             line_vld_q;         // registered line read
  tag_t             line_tag_q;
  cache_pkg::word_t line_data_q;

  index_t req_idx;
  index_t q_idx;
  tag_t   q_tag;
  logic   accept;
  logic   fill;
  logic   hit;

  assign req_idx = addr[INDEX_BITS+1:2];
  assign q_idx   = addr_q[INDEX_BITS+1:2];
  assign q_tag   = addr_q[31:INDEX_BITS+2];
  assign accept  = req && (state == idle);
  assign fill    = (state == wait_mem) && mem_rsp;   // returned word lands here
  assign hit     = line_vld_q && (line_tag_q == q_tag);

  // ----------------------------------------------------------
  // lookup registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q      <= addr;
      line_vld_q  <= valid[req_idx];
      line_tag_q  <= tag_mem[req_idx];
      line_data_q <= data_mem[req_idx];
    end else if (fill) begin           // refresh so the next lookup hits
      line_vld_q  <= 1'b1;
      line_tag_q  <= q_tag;
      line_data_q <= mem_rdata;
    end
  end

  // line arrays
  always_ff @(posedge clk) begin
    if (fill) begin
      tag_mem[q_idx]  <= q_tag;
      data_mem[q_idx] <= mem_rdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;
    end else if (fill) begin
      valid[q_idx] <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // miss fsm
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      idle:     if (req) state_nxt = lookup;
      lookup:   state_nxt = hit ? idle : wait_mem;
      wait_mem: if (mem_rsp) state_nxt = lookup;   // second pass answers
      default:  state_nxt = idle;
    endcase
  end

  // outputs
  assign rsp   = (state == lookup) && hit;
  assign rdata = line_data_q;
  assign busy  = (state != idle);

  assign mem_req = (state == lookup) && !hit;   // one read per miss
  always_comb begin
    mem_req_data.we    = 1'b0;                   // fetch only
    mem_req_data.addr  = addr_q;
    mem_req_data.wdata = '0;
  end

endmodule

/* verilog/dcache.sv */
// ----------------------------------------------------------
// direct mapped data cache, one word per line
// write through with no write allocate
// a store hit updates the line at the req edge
// every store waits for its memory response before rsp
// ----------------------------------------------------------

module dcache #(
  parameter int INDEX_BITS = cache_pkg::INDEX_BITS_DEF
) (
  input  logic                clk,
  input  logic                arst_n,
  // cpu side
  input  logic                req,
  input  cache_pkg::cpu_req_t req_data,
  output logic                rsp,
  output cache_pkg::word_t    rdata,
  output logic                busy,
  // memory side
  output logic                mem_req,
  output cache_pkg::mem_req_t mem_req_data,
  input  logic                mem_rsp,
  input  cache_pkg::word_t    mem_rdata
);

  localparam int LINES    = 1 << INDEX_BITS;
  localparam int TAG_BITS = 30 - INDEX_BITS;

  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]   tag_t;
  typedef enum logic [1:0] {idle, lookup, wait_fill, wait_store} state_t;

  state_t           state;
  state_t           state_nxt;
  logic [LINES-1:0] valid;
  tag_t             tag_mem  [LINES];
  cache_pkg::word_t data_mem [LINES];

  cache_pkg::cpu_req_t req_q;          // request under service
  logic                line_vld_q;
  tag_t                line_tag_q;
  cache_pkg::word_t    line_data_q;

  index_t req_idx;
  tag_t   req_tag;
  index_t q_idx;
  tag_t   q_tag;
  logic   accept;
  logic   st_hit;                      // store that finds its line
  logic   fill;
  logic   hit;

  assign req_idx = req_data.addr[INDEX_BITS+1:2];
  assign req_tag = req_data.addr[31:INDEX_BITS+2];
  assign q_idx   = req_q.addr[INDEX_BITS+1:2];
  assign q_tag   = req_q.addr[31:INDEX_BITS+2];
  assign accept  = req && (state == idle);
  assign st_hit  = accept && req_data.we && valid[req_idx] && (tag_mem[req_idx] == req_tag);
  assign fill    = (state == wait_fill) && mem_rsp;
  assign hit     = line_vld_q && (line_tag_q == q_tag);

  // ----------------------------------------------------------
  // lookup registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q       <= req_data;
      line_vld_q  <= valid[req_idx];
      line_tag_q  <= tag_mem[req_idx];
      line_data_q <= data_mem[req_idx];
    end else if (fill) begin
      line_vld_q  <= 1'b1;              // re-lookup sees the new line
      line_tag_q  <= q_tag;
      line_data_q <= mem_rdata;
    end
  end

  // line arrays, fill and store hit never coincide
  always_ff @(posedge clk) begin
    if (fill) begin
      tag_mem[q_idx]  <= q_tag;
      data_mem[q_idx] <= mem_rdata;
    end else if (st_hit) begin
      data_mem[req_idx] <= req_data.wdata;   // tag already matches
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;
    end else if (fill) begin
      valid[q_idx] <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // read miss and store fsm
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      idle: begin
        if (req) begin
          state_nxt = lookup;
        end
      end
      lookup: begin
        if (req_q.we) begin
          state_nxt = wait_store;          // stores always go out
        end else if (hit) begin
          state_nxt = idle;
        end else begin
          state_nxt = wait_fill;
        end
      end
      wait_fill:  if (mem_rsp) state_nxt = lookup;
      wait_store: if (mem_rsp) state_nxt = idle;
      default:    state_nxt = idle;
    endcase
  end

  // outputs
  assign rsp = ((state == lookup) && !req_q.we && hit) ||
               ((state == wait_store) && mem_rsp);   // store done when memory acks
  assign rdata = line_data_q;                        // don't care for stores
  assign busy  = (state != idle);

  assign mem_req = (state == lookup) && (req_q.we || !hit);
  always_comb begin
    mem_req_data.we    = req_q.we;
    mem_req_data.addr  = req_q.addr;
    mem_req_data.wdata = req_q.wdata;
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  a_no_req_busy: assert property (@(posedge clk) disable iff (!arst_n)
    req |-> !busy)
    else $error("dcache req strobed while busy");

  // at most one memory access in flight per cache
  a_one_mem_req: assert property (@(posedge clk) disable iff (!arst_n)
    mem_req |=> (!mem_req until mem_rsp))
    else $error("dcache issued a second mem_req before mem_rsp");

endmodule

/* verilog/mem_arbiter.sv */
// ----------------------------------------------------------
// two port arbiter in front of main memory
// data port wins when both ports want memory
// only one access outstanding, next issue waits for its rsp
// ----------------------------------------------------------

module mem_arbiter (
  input  logic                clk,
  input  logic                arst_n,
  // instruction cache port
  input  logic                i_req,
  input  cache_pkg::mem_req_t i_req_data,
  // data cache port
  input  logic                d_req,
  input  cache_pkg::mem_req_t d_req_data,
  // responses back to the caches
  output logic                i_rsp,
  output logic                d_rsp,
  output cache_pkg::word_t    rdata,
  // memory side
  output logic                mem_req,
  output cache_pkg::mem_req_t mem_req_data,
  input  logic                mem_rsp,
  input  cache_pkg::word_t    mem_rdata
);

  logic                i_pend;      // strobe held until granted
  logic                d_pend;
  cache_pkg::mem_req_t i_req_q;     // request held with its pending flag
  cache_pkg::mem_req_t d_req_q;
  logic                owner_vld;   // memory access in flight
  logic                owner_d;     // in-flight access belongs to dcache

  logic i_want;
  logic d_want;
  logic grant_i;
  logic grant_d;

  assign i_want  = i_pend || i_req;   // fresh strobe counts at once
  assign d_want  = d_pend || d_req;
  assign grant_d = !owner_vld && d_want;
  assign grant_i = !owner_vld && !d_want && i_want;

  // ----------------------------------------------------------
  // pending flags and ownership
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      i_pend    <= 1'b0;
      d_pend    <= 1'b0;
      owner_vld <= 1'b0;
      owner_d   <= 1'b0;
      mem_req   <= 1'b0;
    end else begin
      i_pend  <= i_want && !grant_i;
      d_pend  <= d_want && !grant_d;
      mem_req <= grant_i || grant_d;    // issue one cycle after grant
      if (grant_i || grant_d) begin
        owner_vld <= 1'b1;
        owner_d   <= grant_d;
      end else if (mem_rsp) begin
        owner_vld <= 1'b0;
      end
    end
  end

  // request payloads
  always_ff @(posedge clk) begin
    if (i_req) begin
      i_req_q <= i_req_data;
    end
    if (d_req) begin
      d_req_q <= d_req_data;
    end
    if (grant_d) begin
      mem_req_data <= d_pend ? d_req_q : d_req_data;
    end else if (grant_i) begin
      mem_req_data <= i_pend ? i_req_q : i_req_data;
    end
  end

  // response routing, same cycle as memory rsp
  assign i_rsp = mem_rsp && !owner_d;
  assign d_rsp = mem_rsp && owner_d;
  assign rdata = mem_rdata;             // both caches see the word

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  a_rsp_owned: assert property (@(posedge clk) disable iff (!arst_n)
    mem_rsp |-> owner_vld)
    else $error("memory response with no owner");

  a_i_no_restrobe: assert property (@(posedge clk) disable iff (!arst_n)
    i_req |-> !i_pend)
    else $error("icache strobed while its request is pending");

  a_d_no_restrobe: assert property (@(posedge clk) disable iff (!arst_n)
    d_req |-> !d_pend)
    else $error("dcache strobed while its request is pending");

endmodule

/* verilog/main_mem.sv */
// ----------------------------------------------------------
// word addressed main memory with fixed response latency
// contents start unknown and have no reset
// address wraps modulo the array size, MEM_LAT must be >= 1
// ----------------------------------------------------------

module main_mem #(
  parameter int MEM_AW  = cache_pkg::MEM_AW_DEF,
  parameter int MEM_LAT = cache_pkg::MEM_LAT_DEF
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                req,
  input  cache_pkg::mem_req_t req_data,
  output logic                rsp,
  output cache_pkg::word_t    rdata
);

  localparam int WORDS = 1 << MEM_AW;

  typedef logic [MEM_AW-1:0] waddr_t;

  cache_pkg::word_t   mem [WORDS];
  waddr_t             waddr;
  logic [MEM_LAT-1:0] vld_pipe;              // one bit per latency stage
  cache_pkg::word_t   data_pipe [MEM_LAT];

  assign waddr = req_data.addr[MEM_AW+1:2];   // drop byte bits and upper bits

  // write lands at the req edge
  always_ff @(posedge clk) begin
    if (req && req_data.we) begin
      mem[waddr] <= req_data.wdata;
    end
  end

  // ----------------------------------------------------------
  // response pipeline
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= req;                      // writes answer too
      for (int i = 1; i < MEM_LAT; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    data_pipe[0] <= mem[waddr];                // old word on a write
    for (int i = 1; i < MEM_LAT; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  assign rsp   = vld_pipe[MEM_LAT-1];
  assign rdata = data_pipe[MEM_LAT-1];

endmodule

/* verilog/cache_subsys.sv */
// ----------------------------------------------------------
// split l1 subsystem with icache and dcache sharing one memory
// no coherence between the two caches
// ----------------------------------------------------------

module cache_subsys #(
  parameter int INDEX_BITS = cache_pkg::INDEX_BITS_DEF,
  parameter int MEM_AW     = cache_pkg::MEM_AW_DEF,
  parameter int MEM_LAT    = cache_pkg::MEM_LAT_DEF
) (
  input  logic                clk,
  input  logic                arst_n,
  // instruction port
  input  logic                i_req,
  input  cache_pkg::addr_t    i_addr,
  output logic                i_rsp,
  output cache_pkg::word_t    i_rdata,
  output logic                i_busy,
  // data port
  input  logic                d_req,
  input  cache_pkg::cpu_req_t d_req_data,
  output logic                d_rsp,
  output cache_pkg::word_t    d_rdata,
  output logic                d_busy
);

  // cache to arbiter
  logic                ic_mem_req;
  cache_pkg::mem_req_t ic_mem_req_data;
  logic                ic_mem_rsp;
  logic                dc_mem_req;
  cache_pkg::mem_req_t dc_mem_req_data;
  logic                dc_mem_rsp;
  cache_pkg::word_t    arb_rdata;        // shared return word

  // arbiter to memory
  logic                mem_req;
  cache_pkg::mem_req_t mem_req_data;
  logic                mem_rsp;
  cache_pkg::word_t    mem_rdata;

  icache #(.INDEX_BITS(INDEX_BITS)) u_icache (
    .clk(clk), .arst_n(arst_n),
    .req(i_req), .addr(i_addr), .rsp(i_rsp), .rdata(i_rdata), .busy(i_busy),
    .mem_req(ic_mem_req), .mem_req_data(ic_mem_req_data),
    .mem_rsp(ic_mem_rsp), .mem_rdata(arb_rdata)
  );

  dcache #(.INDEX_BITS(INDEX_BITS)) u_dcache (
    .clk(clk), .arst_n(arst_n),
    .req(d_req), .req_data(d_req_data), .rsp(d_rsp), .rdata(d_rdata), .busy(d_busy),
    .mem_req(dc_mem_req), .mem_req_data(dc_mem_req_data),
    .mem_rsp(dc_mem_rsp), .mem_rdata(arb_rdata)
  );

  mem_arbiter u_mem_arbiter (
    .clk(clk), .arst_n(arst_n),
    .i_req(ic_mem_req), .i_req_data(ic_mem_req_data),
    .d_req(dc_mem_req), .d_req_data(dc_mem_req_data),
    .i_rsp(ic_mem_rsp), .d_rsp(dc_mem_rsp), .rdata(arb_rdata),
    .mem_req(mem_req), .mem_req_data(mem_req_data),
    .mem_rsp(mem_rsp), .mem_rdata(mem_rdata)
  );

  main_mem #(.MEM_AW(MEM_AW), .MEM_LAT(MEM_LAT)) u_main_mem (
    .clk(clk), .arst_n(arst_n),
    .req(mem_req), .req_data(mem_req_data),
    .rsp(mem_rsp), .rdata(mem_rdata)
  );

endmodule

/* dv/cache_tb.sv */
// ----------------------------------------------------------
// testbench for the split l1 cache subsystem
// memory starts unknown, so every address is stored before it is read
// icache is not snooped, so the table never fetches a word before storing it
// ----------------------------------------------------------

module cache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int INDEX_BITS = 6;
  localparam int MEM_AW     = 12;
  localparam int MEM_LAT    = 4;

  typedef enum {op_store, op_load, op_dual} op_t;

  // one row of the stimulus table
  typedef struct {
    op_t              op;
    bit               on_i;      // load goes to the icache port
    cache_pkg::addr_t addr;      // icache side on a dual row
    cache_pkg::addr_t addr2;     // dcache side on a dual row
    cache_pkg::word_t wdata;
    bit               rnd;       // store data from $urandom
    bit               exp_hit;
  } entry_t;

  logic                clk = 1'b0;
  logic                arst_n;
  logic                i_req;
  cache_pkg::addr_t    i_addr;
  logic                i_rsp;
  cache_pkg::word_t    i_rdata;
  logic                i_busy;
  logic                d_req;
  cache_pkg::cpu_req_t d_req_data;
  logic                d_rsp;
  cache_pkg::word_t    d_rdata;
  logic                d_busy;

  entry_t           tbl[$];
  cache_pkg::word_t sb [int unsigned];   // words stored so far keyed by word address
  int               limit  = 0;
  int               cycles = 0;
  bit               i_acc;               // req taken at the last rising edge
  bit               d_acc;
  bit               i_open;              // request accepted and not yet answered
  bit               d_open;

  cache_subsys #(
    .INDEX_BITS(INDEX_BITS),
    .MEM_AW    (MEM_AW),
    .MEM_LAT   (MEM_LAT)
  ) u_cache_subsys (
    .clk(clk), .arst_n(arst_n),
    .i_req(i_req), .i_addr(i_addr), .i_rsp(i_rsp), .i_rdata(i_rdata), .i_busy(i_busy),
    .d_req(d_req), .d_req_data(d_req_data), .d_rsp(d_rsp), .d_rdata(d_rdata),
    .d_busy(d_busy)
  );

  always #20 clk = ~clk;   // 40 ns period

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  task automatic report_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  // memory wraps modulo its size, so the model does too
  function automatic int unsigned word_index(input cache_pkg::addr_t a);
    return (a >> 2) % (1 << MEM_AW);
  endfunction

  function automatic entry_t make_entry(input op_t op, input bit on_i,
                                        input cache_pkg::addr_t addr,
                                        input cache_pkg::addr_t addr2,
                                        input cache_pkg::word_t wdata,
                                        input bit rnd, input bit exp_hit);
    entry_t e;
    e.op      = op;
    e.on_i    = on_i;
    e.addr    = addr;
    e.addr2   = addr2;
    e.wdata   = wdata;
    e.rnd     = rnd;
    e.exp_hit = exp_hit;
    return e;
  endfunction

  task automatic build_table();
    // a store does not allocate, so the first load misses
    tbl.push_back(make_entry(op_store, 0, 32'h100, 0, 0, 1, 0));
    tbl.push_back(make_entry(op_load,  0, 32'h100, 0, 0, 0, 0));
    tbl.push_back(make_entry(op_load,  0, 32'h100, 0, 0, 0, 1));
    // store hit updates the cached line
    tbl.push_back(make_entry(op_store, 0, 32'h100, 0, 0, 1, 1));
    tbl.push_back(make_entry(op_load,  0, 32'h100, 0, 0, 0, 1));
    // code written through the dcache and then fetched
    tbl.push_back(make_entry(op_store, 0, 32'h200, 0, 32'he3a0_0001, 0, 0));
    tbl.push_back(make_entry(op_store, 0, 32'h204, 0, 32'he280_0002, 0, 0));
    tbl.push_back(make_entry(op_load,  1, 32'h200, 0, 0, 0, 0));
    tbl.push_back(make_entry(op_load,  1, 32'h200, 0, 0, 0, 1));
    tbl.push_back(make_entry(op_load,  1, 32'h204, 0, 0, 0, 0));
    tbl.push_back(make_entry(op_load,  1, 32'h204, 0, 0, 0, 1));
    // 0x040 and 0x140 share index 0x10 with tags 0 and 1
    tbl.push_back(make_entry(op_store, 0, 32'h040, 0, 0, 1, 0));
    tbl.push_back(make_entry(op_store, 0, 32'h140, 0, 0, 1, 0));
    tbl.push_back(make_entry(op_load,  0, 32'h040, 0, 0, 0, 0));
    tbl.push_back(make_entry(op_load,  0, 32'h140, 0, 0, 0, 0));
    tbl.push_back(make_entry(op_load,  0, 32'h040, 0, 0, 0, 0));
    tbl.push_back(make_entry(op_load,  0, 32'h140, 0, 0, 0, 0));
    // both ports strobed together, first missing and then hitting
    tbl.push_back(make_entry(op_store, 0, 32'h300, 0, 0, 1, 0));
    tbl.push_back(make_entry(op_store, 0, 32'h380, 0, 0, 1, 0));
    tbl.push_back(make_entry(op_dual,  0, 32'h300, 32'h380, 0, 0, 0));
    tbl.push_back(make_entry(op_dual,  0, 32'h300, 32'h380, 0, 0, 1));
    tbl.push_back(make_entry(op_load,  0, 32'h200, 0, 0, 0, 0));   // dcache sees code too
  endtask

  // strobe one or both ports, wait for every rsp, count cycles to it
  task automatic run_request(input bit on_i, input bit on_d,
                             input cache_pkg::addr_t ia, input cache_pkg::cpu_req_t dr,
                             output int i_lat, output int d_lat,
                             output cache_pkg::word_t i_word,
                             output cache_pkg::word_t d_word);
    int n;
    n      = 0;
    i_lat  = 0;
    d_lat  = 0;
    i_word = '0;
    d_word = '0;
    i_req      = on_i;             // caller sits at a falling edge with both ports idle
    i_addr     = ia;
    d_req      = on_d;
    d_req_data = dr;
    while ((on_i && i_lat == 0) || (on_d && d_lat == 0)) begin
      @(negedge clk);
      n++;
      i_req = 1'b0;                // single cycle strobe
      d_req = 1'b0;
      if (on_i && i_lat == 0 && i_rsp) begin
        i_lat  = n;
        i_word = i_rdata;
      end
      if (on_d && d_lat == 0 && d_rsp) begin
        d_lat  = n;
        d_word = d_rdata;
      end
    end
    @(negedge clk);                // busy drops the cycle after rsp
    assert (!i_busy && !d_busy) else report_error("busy still high after rsp");
  endtask

  task automatic check_load(input string port, input int n, input bit exp_hit,
                            input bit contended, input int lat,
                            input cache_pkg::word_t got, input cache_pkg::word_t exp);
    bit lat_ok;
    if (exp_hit)
      lat_ok = (lat == 1);
    else if (contended)
      lat_ok = (lat > MEM_LAT + 3);   // waits for the dcache, which wins a tie
    else
      lat_ok = (lat == MEM_LAT + 3);
    assert (lat_ok)
      else report_error($sformatf("entry %0d %s load took %0d cycles, hit expected %0b",
                                  n, port, lat, exp_hit));
    assert (got === exp)
      else report_error($sformatf("entry %0d %s load read %h, expected %h",
                                  n, port, got, exp));
  endtask

  function automatic cache_pkg::word_t expected_word(input cache_pkg::addr_t a);
    return sb[word_index(a)];
  endfunction

  // ----------------------------------------------------------
  // port protocol monitor
  // ----------------------------------------------------------
  // req is stable at the rising edge, rsp and busy in mid cycle
  always @(posedge clk) begin
    i_acc <= i_req;
    d_acc <= d_req;
  end

  always @(negedge clk) begin
    if (arst_n) begin
      if (i_acc)
        i_open = 1'b1;
      if (d_acc)
        d_open = 1'b1;
      assert (i_open || !i_rsp) else report_error("i_rsp without a request");
      assert (d_open || !d_rsp) else report_error("d_rsp without a request");
      assert (i_open || !i_busy) else report_error("i_busy high with no request open");
      assert (d_open || !d_busy) else report_error("d_busy high with no request open");
      if (i_rsp)
        i_open = 1'b0;
      if (d_rsp)
        d_open = 1'b0;
    end
  end

  // cycle limit
  initial begin
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("Some tests failed");
    $fatal(1, "run timed out");
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    entry_t              e;
    cache_pkg::cpu_req_t dr;
    cache_pkg::word_t    wd;
    cache_pkg::word_t    i_word;
    cache_pkg::word_t    d_word;
    int                  i_lat;
    int                  d_lat;
    arst_n     = 1'b0;
    i_req      = 1'b0;
    i_addr     = '0;
    d_req      = 1'b0;
    d_req_data = '0;
    void'($urandom(32'h7a50));     // seeds the generator once
    build_table();
    limit = tbl.size() * (MEM_LAT + 10) + 200;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    foreach (tbl[n]) begin
      e = tbl[n];
      case (e.op)
        op_store: begin
          wd       = e.rnd ? $urandom : e.wdata;
          dr.we    = 1'b1;
          dr.addr  = e.addr;
          dr.wdata = wd;
          run_request(1'b0, 1'b1, '0, dr, i_lat, d_lat, i_word, d_word);
          sb[word_index(e.addr)] = wd;
        end
        op_load: begin
          dr.we    = 1'b0;
          dr.addr  = e.addr;
          dr.wdata = '0;
          run_request(e.on_i, !e.on_i, e.addr, dr, i_lat, d_lat, i_word, d_word);
          if (e.on_i)
            check_load("i", n, e.exp_hit, 1'b0, i_lat, i_word, expected_word(e.addr));
          else
            check_load("d", n, e.exp_hit, 1'b0, d_lat, d_word, expected_word(e.addr));
        end
        default: begin             // fetch and load in the same cycle
          dr.we    = 1'b0;
          dr.addr  = e.addr2;
          dr.wdata = '0;
          run_request(1'b1, 1'b1, e.addr, dr, i_lat, d_lat, i_word, d_word);
          check_load("i", n, e.exp_hit, 1'b1, i_lat, i_word, expected_word(e.addr));
          check_load("d", n, e.exp_hit, 1'b0, d_lat, d_word, expected_word(e.addr2));
        end
      endcase
    end
    $display("All tests passed");
    $finish;
  end

endmodule

/* tb.f */
verilog/cache_pkg.sv
verilog/icache.sv
verilog/dcache.sv
verilog/mem_arbiter.sv
verilog/main_mem.sv
verilog/cache_subsys.sv
dv/cache_tb.sv
